//--- bench/tb_gold_model.svh
`ifndef TB_GOLD_MODEL_SVH
`define TB_GOLD_MODEL_SVH

// reference model of the PBCH DMRS, included inside the testbench module
localparam int GOLD_LEN = pbch_pkg::GOLD_NC + 2 * pbch_pkg::DMRS_SYMS + pbch_pkg::LFSR_N;
localparam logic signed [pbch_pkg::IQ_W - 1 : 0] PILOT_POS = 16'sd8000;
localparam logic signed [pbch_pkg::IQ_W - 1 : 0] PILOT_NEG = -16'sd8000;

bit [1 : 0]        model_sym [pbch_pkg::NUM_IBAR][pbch_pkg::DMRS_SYMS];
bit [1 : 0]        sent_bits [pbch_pkg::NUM_PILOTS];
int                model_corr [pbch_pkg::NUM_IBAR];
int                model_offset;
pbch_pkg::sample_t sym_buf [pbch_pkg::FFT_LEN];

function automatic int c_init_of(input int n_id, input int ibar);
    return (((ibar + 1) * (n_id / 4 + 1)) << 11) + ((ibar + 1) << 6) + n_id % 4;
endfunction

// x1 starts from a single one, x2 from c_init, and c(n) = x1(n + Nc) ^ x2(n + Nc)
task automatic build_pilots(input int n_id);
    bit x1 [GOLD_LEN];
    bit x2 [GOLD_LEN];
    int cinit;
    int n;
    model_offset = n_id % pbch_pkg::PILOT_SPACING;
    for (int ibar = 0; ibar < pbch_pkg::NUM_IBAR; ibar++) begin
        cinit = c_init_of(n_id, ibar);
        for (int j = 0; j < pbch_pkg::LFSR_N; j++) begin
            x1[j] = (j == 0);
            x2[j] = cinit[j];
        end
        for (int j = 0; j + pbch_pkg::LFSR_N < GOLD_LEN; j++) begin
            x1[j + 31] = x1[j + 3] ^ x1[j];
            x2[j + 31] = x2[j + 3] ^ x2[j + 2] ^ x2[j + 1] ^ x2[j];
        end
        for (int m = 0; m < pbch_pkg::DMRS_SYMS; m++) begin
            n = pbch_pkg::GOLD_NC + 2 * m;
            model_sym[ibar][m] = {x1[n] ^ x2[n], x1[n + 1] ^ x2[n + 1]};
        end
    end
endtask

// a set bit sends the negative amplitude, real part in the low half
function automatic pbch_pkg::sample_t pilot_sample(input bit [1 : 0] bits);
    logic signed [pbch_pkg::IQ_W - 1 : 0] re;
    logic signed [pbch_pkg::IQ_W - 1 : 0] im;
    re = bits[1] ? PILOT_NEG : PILOT_POS;
    im = bits[0] ? PILOT_NEG : PILOT_POS;
    return {im, re};
endfunction

// flips may hit the same bit twice, sent_bits keeps what really goes out
task automatic build_symbol(input int ibar, input int flips);
    int m;
    int pos;
    m = 0;
    for (int p = 0; p < pbch_pkg::NUM_PILOTS; p++) begin
        sent_bits[p] = model_sym[ibar][p];
    end
    for (int f = 0; f < flips; f++) begin
        pos = $unsigned($random(seed)) % (2 * pbch_pkg::NUM_PILOTS);
        sent_bits[pos / 2][pos % 2] = !sent_bits[pos / 2][pos % 2];
    end
    for (int k = 0; k < pbch_pkg::FFT_LEN; k++) begin
        if ((k + pbch_pkg::PILOT_SPACING - model_offset) % pbch_pkg::PILOT_SPACING == 0) begin
            sym_buf[k] = pilot_sample(sent_bits[m]);
            m++;
        end else begin
            sym_buf[k] = $random(seed);
        end
    end
endtask

// count matching bits per candidate, the lowest ibar keeps a tie
task automatic score_candidates(output pbch_pkg::ibar_t best_ibar,
                                output pbch_pkg::corr_t best_corr);
    int best;
    best = 0;
    for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
        model_corr[i] = 0;
        for (int m = 0; m < pbch_pkg::NUM_PILOTS; m++) begin
            for (int b = 0; b < 2; b++) begin
                if (sent_bits[m][b] == model_sym[i][m][b]) begin
                    model_corr[i]++;
                end
            end
        end
        if (model_corr[i] > model_corr[best]) begin
            best = i;
        end
    end
    best_ibar = pbch_pkg::ibar_t'(best);
    best_corr = pbch_pkg::corr_t'(model_corr[best]);
endtask

`endif

//--- bench/tb_pbch_ibar_estimator.sv
`timescale 1ns/100ps

module tb_pbch_ibar_estimator;

    // six generations and twenty symbols fit well inside this bound
    localparam int CYCLE_LIMIT = 60000;
    localparam int READY_LATENCY = 1746;

    logic              clk_i;
    logic              reset_ni;
    pbch_pkg::sample_t sample_i;
    logic              sample_valid_i;
    pbch_pkg::n_id_t   n_id_i;
    logic              n_id_valid_i;
    logic              pbch_start_i;
    logic              dmrs_ready_o;
    pbch_pkg::ibar_t   ibar_o;
    pbch_pkg::corr_t   corr_o;
    logic              ibar_valid_o;

    integer seed;
    int     error_count;
    int     test_count;
    int     failed_tests;
    int     cycle_count;

    `include "tb_gold_model.svh"

    pbch_ibar_estimator u_pbch_ibar_estimator (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sample_i      (sample_i),
        .sample_valid_i(sample_valid_i),
        .n_id_i        (n_id_i),
        .n_id_valid_i  (n_id_valid_i),
        .pbch_start_i  (pbch_start_i),
        .dmrs_ready_o  (dmrs_ready_o),
        .ibar_o        (ibar_o),
        .corr_o        (corr_o),
        .ibar_valid_o  (ibar_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic compare_ibar(input pbch_pkg::ibar_t got, input pbch_pkg::ibar_t exp,
                                input string what);
        if (got !== exp) begin
            $display("error at %0t: %s ibar_o is %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_corr(input pbch_pkg::corr_t got, input pbch_pkg::corr_t exp,
                                input string what);
        if (got !== exp) begin
            $display("error at %0t: %s corr_o is %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("failure at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // returns on the falling edge after the strobe cycle
    task automatic load_cell_id(input int n_id);
        @(negedge clk_i);
        n_id_i       = pbch_pkg::n_id_t'(n_id);
        n_id_valid_i = 1'b1;
        @(negedge clk_i);
        n_id_valid_i = 1'b0;
    endtask

    // counts from one, the edge right after the strobe
    task automatic wait_for_ready(input int limit, output int cycles, output bit seen);
        cycles = 1;
        seen   = 1'b0;
        while (!seen && cycles <= limit) begin
            if (dmrs_ready_o) begin
                seen = 1'b1;
            end else begin
                @(negedge clk_i);
                cycles++;
            end
        end
    endtask

    task automatic send_symbol(input bit gaps);
        @(negedge clk_i);
        pbch_start_i = 1'b1;
        @(negedge clk_i);
        pbch_start_i = 1'b0;
        for (int k = 0; k < pbch_pkg::FFT_LEN; k++) begin
            if (gaps) begin
                while ($unsigned($random(seed)) % 4 == 0) begin
                    sample_valid_i = 1'b0;
                    @(negedge clk_i);
                end
            end
            sample_i       = sym_buf[k];
            sample_valid_i = 1'b1;
            @(negedge clk_i);
        end
        sample_valid_i = 1'b0;
        sample_i       = '0;
    endtask

    task automatic wait_for_result(input int limit, output bit seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < limit) begin
            if (ibar_valid_o) begin
                seen = 1'b1;
            end else begin
                @(negedge clk_i);
                cycles++;
            end
        end
    endtask

    task automatic detect_and_check(input string label, input bit gaps);
        pbch_pkg::ibar_t exp_ibar;
        pbch_pkg::corr_t exp_corr;
        bit              seen;
        score_candidates(exp_ibar, exp_corr);
        send_symbol(gaps);
        wait_for_result(20, seen);
        if (!seen) begin
            report_failure({label, " gave no ibar_valid_o pulse"});
        end else begin
            compare_ibar(ibar_o, exp_ibar, label);
            compare_corr(corr_o, exp_corr, label);
        end
    endtask

    task automatic test_after_reset();
        int errors_before;
        bit pulsed;
        bit ready_seen;
        errors_before = error_count;
        pulsed        = 1'b0;
        ready_seen    = 1'b0;
        build_pilots(0);
        build_symbol(0, 0);
        send_symbol(1'b0);
        for (int c = 0; c < 400; c++) begin
            pulsed     = pulsed | ibar_valid_o;
            ready_seen = ready_seen | dmrs_ready_o;
            @(negedge clk_i);
        end
        if (pulsed) begin
            report_failure("ibar_valid_o pulsed before any pilots existed");
        end
        if (ready_seen) begin
            report_failure("dmrs_ready_o rose without a cell ID");
        end
        finish_test("after reset", errors_before);
    endtask

    task automatic test_generation();
        int errors_before;
        int cycles;
        bit seen;
        errors_before = error_count;
        load_cell_id('h1A7);
        build_pilots('h1A7);
        wait_for_ready(2000, cycles, seen);
        if (!seen) begin
            report_failure("dmrs_ready_o never rose after the cell ID");
        end else if (cycles != READY_LATENCY) begin
            $display("error at %0t: dmrs_ready_o rose after %0d cycles, expected %0d",
                     $time, cycles, READY_LATENCY);
            error_count++;
        end
        finish_test("pilot generation", errors_before);
    endtask

    task automatic test_clean_detection();
        int errors_before;
        errors_before = error_count;
        for (int ibar = 0; ibar < pbch_pkg::NUM_IBAR; ibar++) begin
            build_symbol(ibar, 0);
            detect_and_check("clean symbol", 1'b0);
            compare_ibar(ibar_o, pbch_pkg::ibar_t'(ibar), "clean symbol");
            compare_corr(corr_o, pbch_pkg::corr_t'(2 * pbch_pkg::NUM_PILOTS), "clean symbol");
        end
        finish_test("clean detection", errors_before);
    endtask

    task automatic test_noisy_detection();
        int errors_before;
        int ibar;
        int flips;
        errors_before = error_count;
        for (int t = 0; t < 6; t++) begin
            ibar  = $unsigned($random(seed)) % pbch_pkg::NUM_IBAR;
            flips = $unsigned($random(seed)) % 21;
            build_symbol(ibar, flips);
            detect_and_check("noisy symbol", 1'b1);
        end
        finish_test("noisy detection", errors_before);
    endtask

    task automatic test_restart();
        int errors_before;
        int cycles;
        bit seen;
        errors_before = error_count;
        load_cell_id('h0F2);
        if (dmrs_ready_o) begin
            report_failure("dmrs_ready_o stayed high after a new cell ID");
        end
        build_pilots('h0F2);
        wait_for_ready(2000, cycles, seen);
        if (!seen) begin
            report_failure("dmrs_ready_o never rose again after the new cell ID");
        end else begin
            build_symbol(3, 0);
            detect_and_check("restart clean symbol", 1'b0);
            build_symbol(6, 12);
            detect_and_check("restart noisy symbol", 1'b1);
        end
        finish_test("restart on new cell ID", errors_before);
    endtask

    // the old symbol is sent while the new pilots are still being generated
    task automatic test_start_during_generation();
        int errors_before;
        int cycles;
        bit pulsed;
        errors_before = error_count;
        pulsed        = 1'b0;
        cycles        = 0;
        load_cell_id('h3E9);
        send_symbol(1'b0);
        while (!dmrs_ready_o && cycles < 2000) begin
            pulsed = pulsed | ibar_valid_o;
            @(negedge clk_i);
            cycles++;
        end
        if (pulsed) begin
            report_failure("a start during generation produced a result");
        end
        if (!dmrs_ready_o) begin
            report_failure("dmrs_ready_o never rose after the last cell ID");
        end else begin
            build_pilots('h3E9);
            build_symbol(5, 8);
            detect_and_check("symbol after generation", 1'b1);
        end
        finish_test("start during generation", errors_before);
    endtask

    initial begin
        seed           = 32'h7d3ec454;
        error_count    = 0;
        test_count     = 0;
        failed_tests   = 0;
        reset_ni       = 1'b0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        n_id_i         = '0;
        n_id_valid_i   = 1'b0;
        pbch_start_i   = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_ni = 1'b1;
        test_after_reset();
        test_generation();
        test_clean_detection();
        test_noisy_detection();
        test_restart();
        test_start_during_generation();
        $display("summary: %0d tests run, %0d failed, %0d errors",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- common/pbch_pkg.sv
package pbch_pkg;

    // Gold sequence generator
    localparam int LFSR_N = 31;
    localparam int GOLD_NC = 1600;

    // PBCH DMRS: 144 Gold bits per ibar, stored as 72 QPSK symbols
    localparam int DMRS_SYMS = 72;
    localparam int NUM_IBAR = 8;

    // PBCH symbol layout, pilots on every 4th subcarrier
    localparam int FFT_LEN = 256;
    localparam int PILOT_SPACING = 4;
    localparam int NUM_PILOTS = 64;

    // one IQ sample with the real part in the low half
    localparam int IQ_W = 16;
    localparam int SAMPLE_W = 32;

    localparam int MAX_CELL_ID = 1007;

    typedef logic [$clog2(MAX_CELL_ID + 1) - 1 : 0] n_id_t;

    typedef logic [$clog2(NUM_IBAR) - 1 : 0] ibar_t;

    // bit 1 holds c(2m) and bit 0 holds c(2m+1)
    typedef logic [1 : 0] qpsk_t;

    typedef logic [$clog2(DMRS_SYMS) - 1 : 0] dmrs_idx_t;

    // one extra bit so the count can rest at FFT_LEN once the symbol is complete
    typedef logic [$clog2(FFT_LEN + 1) - 1 : 0] sc_idx_t;

    // two bits compared per pilot
    typedef logic [$clog2(2 * NUM_PILOTS + 1) - 1 : 0] corr_t;

    typedef logic [SAMPLE_W - 1 : 0] sample_t;

    typedef logic [LFSR_N - 1 : 0] lfsr_state_t;

    // covers the skipped bits and the stored bits of one generation
    typedef logic [$clog2(GOLD_NC + 2 * DMRS_SYMS) - 1 : 0] gen_cnt_t;

endpackage

//--- detect/dmrs_correlator.sv
`timescale 1ns/100ps

module dmrs_correlator (
    input  logic                                           clk_i,
    input  logic                                           reset_ni,
    input  pbch_pkg::sample_t                              sample_i,
    input  logic                                           sample_valid_i,
    input  logic                                           busy_i,
    input  logic                                           clear_i,
    input  logic [$clog2(pbch_pkg::PILOT_SPACING) - 1 : 0] pilot_offset_i,
    input  pbch_pkg::qpsk_t [pbch_pkg::NUM_IBAR - 1 : 0]   rd_syms_i,
    output pbch_pkg::dmrs_idx_t                            rd_idx_o,
    output logic                                           done_o,
    output pbch_pkg::corr_t [pbch_pkg::NUM_IBAR - 1 : 0]   corr_o
);

    logic                accept;
    logic                is_pilot;
    logic                pilot_q;
    logic                last_q;
    pbch_pkg::sample_t   samp_q;
    pbch_pkg::sc_idx_t   sc_cnt_q;
    pbch_pkg::dmrs_idx_t pilot_cnt_q;
    pbch_pkg::qpsk_t     demod;

    // the counter rests at FFT_LEN, so extra samples after the symbol are dropped
    assign accept   = busy_i && sample_valid_i &&
                      (sc_cnt_q != pbch_pkg::sc_idx_t'(pbch_pkg::FFT_LEN));
    assign is_pilot = (sc_cnt_q[$clog2(pbch_pkg::PILOT_SPACING) - 1 : 0] == pilot_offset_i);

    // the read is issued with the sample, so memory data lines up with samp_q
    assign rd_idx_o = pilot_cnt_q;

    // hard QPSK decision, a negative component gives a one
    assign demod = {samp_q[pbch_pkg::IQ_W - 1], samp_q[pbch_pkg::SAMPLE_W - 1]};

    always_ff @(posedge clk_i) begin
        if (accept) begin
            samp_q <= sample_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni || clear_i) begin
            sc_cnt_q    <= '0;
            pilot_cnt_q <= '0;
            pilot_q     <= 1'b0;
            last_q      <= 1'b0;
            done_o      <= 1'b0;
            corr_o      <= '0;
        end else begin
            pilot_q <= accept && is_pilot;
            last_q  <= accept && (sc_cnt_q == pbch_pkg::sc_idx_t'(pbch_pkg::FFT_LEN - 1));
            done_o  <= last_q;
            if (accept) begin
                sc_cnt_q <= sc_cnt_q + 1'b1;
                if (is_pilot) begin
                    pilot_cnt_q <= pilot_cnt_q + 1'b1;
                end
            end
            if (pilot_q) begin
                for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
                    corr_o[i] <= corr_o[i]
                        + pbch_pkg::corr_t'(demod[1] == rd_syms_i[i][1])
                        + pbch_pkg::corr_t'(demod[0] == rd_syms_i[i][0]);
                end
            end
        end
    end

    // every offset places the same number of pilots in one symbol
    a_pilots_per_symbol : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        done_o |-> (pilot_cnt_q == pbch_pkg::dmrs_idx_t'(pbch_pkg::NUM_PILOTS))
    );

endmodule

//--- detect/ibar_detector.sv
`timescale 1ns/100ps

module ibar_detector (
    input  logic                                         clk_i,
    input  logic                                         reset_ni,
    input  logic                                         pbch_start_i,
    input  logic                                         dmrs_ready_i,
    input  logic                                         done_i,
    input  pbch_pkg::corr_t [pbch_pkg::NUM_IBAR - 1 : 0] corr_i,
    output logic                                         busy_o,
    output logic                                         clear_o,
    output pbch_pkg::ibar_t                              ibar_o,
    output pbch_pkg::corr_t                              corr_o,
    output logic                                         ibar_valid_o
);

    typedef enum logic [1 : 0] {
        ST_IDLE,
        ST_COLLECT,
        ST_DECIDE
    } state_t;

    state_t          state_q;
    logic            start_ok;
    pbch_pkg::ibar_t best_ibar;
    pbch_pkg::corr_t best_corr;

    // starts are only taken with valid pilots and no symbol in flight
    assign start_ok = (state_q == ST_IDLE) && pbch_start_i && dmrs_ready_i;

    // clearing in the start cycle leaves the first sample free to follow directly
    assign clear_o      = start_ok;
    assign busy_o       = (state_q == ST_COLLECT);
    assign ibar_valid_o = (state_q == ST_DECIDE);

    // a later candidate must beat the current best strictly, so ties go to the lowest ibar
    always_comb begin
        best_ibar = '0;
        best_corr = corr_i[0];
        for (int i = 1; i < pbch_pkg::NUM_IBAR; i++) begin
            if (corr_i[i] > best_corr) begin
                best_ibar = pbch_pkg::ibar_t'(i);
                best_corr = corr_i[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_ok) begin
                        state_q <= ST_COLLECT;
                    end
                end
                ST_COLLECT: begin
                    if (done_i) begin
                        state_q <= ST_DECIDE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // the result is held until the next detection replaces it
    always_ff @(posedge clk_i) begin
        if ((state_q == ST_COLLECT) && done_i) begin
            ibar_o <= best_ibar;
            corr_o <= best_corr;
        end
    end

    a_single_valid : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_o |=> !ibar_valid_o
    );

endmodule

//--- dmrs/dmrs_generator.sv
`timescale 1ns/100ps

module dmrs_generator (
    input  logic                                          clk_i,
    input  logic                                          reset_ni,
    input  pbch_pkg::n_id_t                               n_id_i,
    input  logic                                          n_id_valid_i,
    output logic                                          wr_en_o,
    output pbch_pkg::dmrs_idx_t                           wr_idx_o,
    output pbch_pkg::qpsk_t [pbch_pkg::NUM_IBAR - 1 : 0]  wr_bits_o,
    output logic [$clog2(pbch_pkg::PILOT_SPACING) - 1 : 0] pilot_offset_o,
    output logic                                          dmrs_ready_o
);

    logic                                  running_q;
    pbch_pkg::gen_cnt_t                    cnt_q;
    pbch_pkg::gen_cnt_t                    store_pos;
    logic                                  storing;
    logic                                  x1_bit;
    logic [pbch_pkg::NUM_IBAR - 1 : 0]     x2_bit;
    logic [pbch_pkg::NUM_IBAR - 1 : 0]     gold_bit;
    logic [pbch_pkg::NUM_IBAR - 1 : 0]     hi_bits_q;

    // x1 always starts from 1
    gold_lfsr #(
        .TAPS('h9)
    ) u_x1_lfsr (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .load_i  (n_id_valid_i),
        .seed_i  (pbch_pkg::lfsr_state_t'(1)),
        .bit_o   (x1_bit)
    );

    for (genvar i = 0; i < pbch_pkg::NUM_IBAR; i++) begin : g_x2
        pbch_pkg::lfsr_state_t c_init;

        // c_init = 2^11 (ibar+1)(floor(N_id/4)+1) + 2^6 (ibar+1) + (N_id mod 4)
        assign c_init = pbch_pkg::lfsr_state_t'(
            (((i + 1) * (32'(n_id_i[$bits(n_id_i) - 1 : 2]) + 1)) << 11)
            + ((i + 1) << 6)
            + 32'(n_id_i[1 : 0]));

        gold_lfsr #(
            .TAPS('hF)
        ) u_x2_lfsr (
            .clk_i   (clk_i),
            .reset_ni(reset_ni),
            .load_i  (n_id_valid_i),
            .seed_i  (c_init),
            .bit_o   (x2_bit[i])
        );

        assign gold_bit[i] = x1_bit ^ x2_bit[i];
    end

    // cnt_q equals the LFSR step n, so the stored bits start at n = GOLD_NC
    assign storing   = running_q && (cnt_q >= pbch_pkg::gen_cnt_t'(pbch_pkg::GOLD_NC));
    assign store_pos = cnt_q - pbch_pkg::gen_cnt_t'(pbch_pkg::GOLD_NC);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            running_q      <= 1'b0;
            cnt_q          <= '0;
            wr_en_o        <= 1'b0;
            dmrs_ready_o   <= 1'b0;
            pilot_offset_o <= '0;
        end else if (n_id_valid_i) begin
            // a new cell ID abandons whatever generation was running
            running_q      <= 1'b1;
            cnt_q          <= '0;
            wr_en_o        <= 1'b0;
            dmrs_ready_o   <= 1'b0;
            pilot_offset_o <= n_id_i[$bits(pilot_offset_o) - 1 : 0];
        end else begin
            // write once the odd bit of a pair has arrived
            wr_en_o <= storing && store_pos[0];
            if (running_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == pbch_pkg::gen_cnt_t'(pbch_pkg::GOLD_NC + 2 * pbch_pkg::DMRS_SYMS - 1)) begin
                    running_q <= 1'b0;
                end
            end
            if (wr_en_o && (wr_idx_o == pbch_pkg::dmrs_idx_t'(pbch_pkg::DMRS_SYMS - 1))) begin
                dmrs_ready_o <= 1'b1;
            end
        end
    end

    // even bits wait in hi_bits_q for their odd partner
    always_ff @(posedge clk_i) begin
        if (storing) begin
            if (!store_pos[0]) begin
                hi_bits_q <= gold_bit;
            end else begin
                wr_idx_o <= store_pos[$bits(pbch_pkg::dmrs_idx_t) : 1];
                for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
                    wr_bits_o[i] <= {hi_bits_q[i], gold_bit[i]};
                end
            end
        end
    end

    // the memory must be complete before anyone is told it is ready
    a_no_write_when_ready : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        dmrs_ready_o |-> !wr_en_o
    );

endmodule

//--- dmrs/dmrs_memory.sv
`timescale 1ns/100ps

module dmrs_memory (
    input  logic                                         clk_i,
    input  logic                                         wr_en_i,
    input  pbch_pkg::dmrs_idx_t                          wr_idx_i,
    input  pbch_pkg::qpsk_t [pbch_pkg::NUM_IBAR - 1 : 0] wr_bits_i,
    input  pbch_pkg::dmrs_idx_t                          rd_idx_i,
    output pbch_pkg::qpsk_t [pbch_pkg::NUM_IBAR - 1 : 0] rd_syms_o
);

    // one row per DMRS index, holding the symbol of every ibar
    pbch_pkg::qpsk_t [pbch_pkg::NUM_IBAR - 1 : 0] mem_q [pbch_pkg::DMRS_SYMS];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_bits_i;
        end
    end

    // all eight candidates come out together one cycle after the index
    always_ff @(posedge clk_i) begin
        rd_syms_o <= mem_q[rd_idx_i];
    end

    // the generator sequencing must never step past the last symbol
    a_wr_idx_in_range : assert property (
        @(posedge clk_i)
        wr_en_i |-> (wr_idx_i < pbch_pkg::dmrs_idx_t'(pbch_pkg::DMRS_SYMS))
    );

endmodule

//--- list.f
+incdir+bench
common/pbch_pkg.sv
src/gold_lfsr.sv
dmrs/dmrs_generator.sv
dmrs/dmrs_memory.sv
detect/dmrs_correlator.sv
detect/ibar_detector.sv
src/pbch_ibar_estimator.sv
bench/tb_pbch_ibar_estimator.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f list.f --top-module tb_pbch_ibar_estimator -o tb_sim \
    && ./obj_dir/tb_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "simulation did not build or run"; exit 1; }

cat "$LOG"

grep -q "ALL TESTS PASSED" "$LOG" \
    && exit 0 \
    || exit 1

//--- src/gold_lfsr.sv
`timescale 1ns/100ps

module gold_lfsr #(
    parameter pbch_pkg::lfsr_state_t TAPS = 'h9
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  logic                  load_i,
    input  pbch_pkg::lfsr_state_t seed_i,
    output logic                  bit_o
);

    // state[j] holds x(n+j), so bit 0 is the oldest bit of the window
    pbch_pkg::lfsr_state_t state_q;
    logic                  feedback;

    // x(n+31) is the XOR of every tapped x(n+j)
    assign feedback = ^(state_q & TAPS);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            // an all-zero state would never leave zero
            state_q <= pbch_pkg::lfsr_state_t'(1);
        end else if (load_i) begin
            state_q <= seed_i;
        end else begin
            state_q <= {feedback, state_q[pbch_pkg::LFSR_N - 1 : 1]};
        end
    end

    assign bit_o = state_q[0];

endmodule

//--- src/pbch_ibar_estimator.sv
`timescale 1ns/100ps

module pbch_ibar_estimator (
    input  logic              clk_i,
    input  logic              reset_ni,
    input  pbch_pkg::sample_t sample_i,
    input  logic              sample_valid_i,
    input  pbch_pkg::n_id_t   n_id_i,
    input  logic              n_id_valid_i,
    input  logic              pbch_start_i,
    output logic              dmrs_ready_o,
    output pbch_pkg::ibar_t   ibar_o,
    output pbch_pkg::corr_t   corr_o,
    output logic              ibar_valid_o
);

    logic                                           wr_en;
    pbch_pkg::dmrs_idx_t                            wr_idx;
    pbch_pkg::qpsk_t [pbch_pkg::NUM_IBAR - 1 : 0]   wr_bits;
    logic [$clog2(pbch_pkg::PILOT_SPACING) - 1 : 0] pilot_offset;
    pbch_pkg::dmrs_idx_t                            rd_idx;
    pbch_pkg::qpsk_t [pbch_pkg::NUM_IBAR - 1 : 0]   rd_syms;
    logic                                           busy;
    logic                                           clear;
    logic                                           done;
    pbch_pkg::corr_t [pbch_pkg::NUM_IBAR - 1 : 0]   corr;

    dmrs_generator u_dmrs_generator (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .n_id_i        (n_id_i),
        .n_id_valid_i  (n_id_valid_i),
        .wr_en_o       (wr_en),
        .wr_idx_o      (wr_idx),
        .wr_bits_o     (wr_bits),
        .pilot_offset_o(pilot_offset),
        .dmrs_ready_o  (dmrs_ready_o)
    );

    dmrs_memory u_dmrs_memory (
        .clk_i    (clk_i),
        .wr_en_i  (wr_en),
        .wr_idx_i (wr_idx),
        .wr_bits_i(wr_bits),
        .rd_idx_i (rd_idx),
        .rd_syms_o(rd_syms)
    );

    dmrs_correlator u_dmrs_correlator (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sample_i      (sample_i),
        .sample_valid_i(sample_valid_i),
        .busy_i        (busy),
        .clear_i       (clear),
        .pilot_offset_i(pilot_offset),
        .rd_syms_i     (rd_syms),
        .rd_idx_o      (rd_idx),
        .done_o        (done),
        .corr_o        (corr)
    );

    ibar_detector u_ibar_detector (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .pbch_start_i(pbch_start_i),
        .dmrs_ready_i(dmrs_ready_o),
        .done_i      (done),
        .corr_i      (corr),
        .busy_o      (busy),
        .clear_o     (clear),
        .ibar_o      (ibar_o),
        .corr_o      (corr_o),
        .ibar_valid_o(ibar_valid_o)
    );

endmodule
